// File: logic/udp_echo_pkg.sv
// UDP echo package with echo constants, field types and FSM state encodings
package udp_echo_pkg;

    // Destination port that gets echoed back
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Local node address 192.168.1.128, used as the reply source by the stack
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Reply TTL handed to the downstream IP layer
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Payload buffer depth in beats
    localparam int PAYLOAD_FIFO_DEPTH = 64;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_len_t;

    // Payload gate FSM
    typedef enum logic [1:0] {
        GATE_WAIT,
        GATE_PASS,
        GATE_DROP
    } gate_state_t;

    // Frame sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_HDR,
        SEQ_PAYLOAD
    } seq_state_t;

endpackage

// File: logic/udp_stream_if.sv
// Byte stream interface carrying payload beats with valid/ready handshake
`timescale 1ns/100ps

interface udp_stream_if import udp_echo_pkg::*; ();

    byte_t tdata;
    logic  tvalid;
    logic  tready;
    logic  tlast;
    logic  tuser;

    // Source drives the beat, destination drives back-pressure
    modport src (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport dst (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

// File: logic/reply_hdr_if.sv
// Reply header interface from the header path to the frame sequencer
`timescale 1ns/100ps

interface reply_hdr_if import udp_echo_pkg::*; ();

    logic      valid;
    logic      ready;
    ip_addr_t  dest_ip;
    udp_port_t source_port;
    udp_port_t dest_port;
    udp_len_t  length;

    modport src (
        output valid, dest_ip, source_port, dest_port, length,
        input  ready
    );

    // Sequencer side, only ready flows back
    modport dst (
        input  valid, dest_ip, source_port, dest_port, length,
        output ready
    );

endinterface

// File: logic/echo_header_path.sv
// Echo header path that matches the port, issues a verdict and buffers the reply header
`timescale 1ns/100ps

module echo_header_path import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_hdr_valid,
    output logic      rx_hdr_ready,
    input  ip_addr_t  rx_source_ip,
    input  udp_port_t rx_source_port,
    input  udp_port_t rx_dest_port,
    input  udp_len_t  rx_length,
    output logic      verdict_valid,
    output logic      verdict_match,
    input  logic      verdict_ready,
    reply_hdr_if.src  reply
);

    logic run;
    logic port_match;
    logic hdr_take;

    assign port_match = rx_dest_port == ECHO_PORT;

    // Both slots must be empty before a new header is taken
    assign rx_hdr_ready = run && !verdict_valid && !reply.valid;
    assign hdr_take = rx_hdr_valid && rx_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
            verdict_valid <= 1'b0;
            reply.valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (verdict_valid && verdict_ready) begin
                verdict_valid <= 1'b0;
            end
            if (reply.valid && reply.ready) begin
                reply.valid <= 1'b0;
            end
            if (hdr_take) begin
                verdict_valid <= 1'b1;
                reply.valid <= port_match;
            end
        end
    end

    // Reply swaps the ports and answers to the sender
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            verdict_match <= port_match;
            reply.dest_ip <= rx_source_ip;
            reply.source_port <= rx_dest_port;
            reply.dest_port <= rx_source_port;
            reply.length <= rx_length;
        end
    end

    a_reply_held: assert property (@(posedge clk) disable iff (rst)
        reply.valid && !reply.ready |=> reply.valid && $stable(reply.dest_ip));

endmodule

// File: logic/echo_payload_gate.sv
// Payload gate that forwards or discards each frame according to its verdict
`timescale 1ns/100ps

module echo_payload_gate import udp_echo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     verdict_valid,
    input  logic     verdict_match,
    output logic     verdict_ready,
    input  byte_t    rx_payload_tdata,
    input  logic     rx_payload_tvalid,
    output logic     rx_payload_tready,
    input  logic     rx_payload_tlast,
    input  logic     rx_payload_tuser,
    udp_stream_if.src out
);

    gate_state_t state;
    logic        frame_end;

    // One verdict per frame is taken between frames
    assign verdict_ready = state == GATE_WAIT;

    // Drop frames are sunk at full rate while pass frames follow the FIFO
    assign rx_payload_tready = (state == GATE_PASS && out.tready) || state == GATE_DROP;
    assign frame_end = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    assign out.tvalid = rx_payload_tvalid && state == GATE_PASS;
    assign out.tdata = rx_payload_tdata;
    assign out.tlast = rx_payload_tlast;
    assign out.tuser = rx_payload_tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GATE_WAIT;
        end else begin
            case (state)
                GATE_WAIT: begin
                    if (verdict_valid) begin
                        state <= verdict_match ? GATE_PASS : GATE_DROP;
                    end
                end
                GATE_PASS, GATE_DROP: begin
                    if (frame_end) begin
                        state <= GATE_WAIT;
                    end
                end
                default: state <= GATE_WAIT;
            endcase
        end
    end

    // After a frame ends, or while no verdict is held, the next cycle takes no beat
    a_no_beat_in_wait: assert property (@(posedge clk) disable iff (rst)
        frame_end || (state == GATE_WAIT && !verdict_valid) |=> !rx_payload_tready);

endmodule

// File: logic/payload_fifo.sv
// Synchronous stream FIFO holding the payload of matched frames
`timescale 1ns/100ps

module payload_fifo import udp_echo_pkg::*; #(
    parameter int DEPTH = PAYLOAD_FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    udp_stream_if.dst in,
    udp_stream_if.src out
);

    // Entry is {tuser, tlast, tdata}
    logic [$bits(byte_t)+1:0] mem [DEPTH];

    // Extra top bit tells full from empty
    logic [$clog2(DEPTH):0]   wr_ptr;
    logic [$clog2(DEPTH):0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_addr;
    logic [$clog2(DEPTH)-1:0] rd_addr;
    logic                     full;
    logic                     empty;
    logic                     do_write;
    logic                     do_read;

    assign wr_addr = wr_ptr[$clog2(DEPTH)-1:0];
    assign rd_addr = rd_ptr[$clog2(DEPTH)-1:0];
    assign empty = wr_ptr == rd_ptr;
    assign full = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) && (wr_addr == rd_addr);

    assign in.tready = !full;
    assign out.tvalid = !empty;
    assign {out.tuser, out.tlast, out.tdata} = mem[rd_addr];

    assign do_write = in.tvalid && in.tready;
    assign do_read = out.tvalid && out.tready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_addr] <= {in.tuser, in.tlast, in.tdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + do_write;
            rd_ptr <= rd_ptr + do_read;
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        full && !do_read |=> wr_ptr == $past(wr_ptr));

endmodule

// File: logic/echo_frame_sequencer.sv
// Frame sequencer sending each reply header and then its payload, with LED capture
`timescale 1ns/100ps

module echo_frame_sequencer import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    reply_hdr_if.dst  hdr,
    udp_stream_if.dst in,
    output logic      tx_hdr_valid,
    input  logic      tx_hdr_ready,
    output ip_addr_t  tx_dest_ip,
    output udp_port_t tx_source_port,
    output udp_port_t tx_dest_port,
    output udp_len_t  tx_length,
    output byte_t     tx_payload_tdata,
    output logic      tx_payload_tvalid,
    input  logic      tx_payload_tready,
    output logic      tx_payload_tlast,
    output logic      tx_payload_tuser,
    output byte_t     led
);

    seq_state_t state;
    logic       first_beat;
    logic       hdr_take;
    logic       hdr_sent;
    logic       beat_go;

    assign hdr.ready = state == SEQ_IDLE;
    assign hdr_take = hdr.valid && hdr.ready;
    assign tx_hdr_valid = state == SEQ_HDR;
    assign hdr_sent = tx_hdr_valid && tx_hdr_ready;

    // Payload flows only after the header went out
    assign tx_payload_tvalid = in.tvalid && state == SEQ_PAYLOAD;
    assign in.tready = tx_payload_tready && state == SEQ_PAYLOAD;
    assign tx_payload_tdata = in.tdata;
    assign tx_payload_tlast = in.tlast;
    assign tx_payload_tuser = in.tuser;
    assign beat_go = tx_payload_tvalid && tx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            first_beat <= 1'b0;
            led <= '0;
        end else begin
            case (state)
                SEQ_IDLE: if (hdr_take) state <= SEQ_HDR;
                SEQ_HDR: begin
                    if (hdr_sent) begin
                        state <= SEQ_PAYLOAD;
                        first_beat <= 1'b1;
                    end
                end
                SEQ_PAYLOAD: if (beat_go && in.tlast) state <= SEQ_IDLE;
                default: state <= SEQ_IDLE;
            endcase
            if (beat_go && first_beat) begin
                led <= in.tdata;
                first_beat <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            tx_dest_ip <= hdr.dest_ip;
            tx_source_port <= hdr.source_port;
            tx_dest_port <= hdr.dest_port;
            tx_length <= hdr.length;
        end
    end

    // Payload stops once a frame ends or a new header is taken
    a_payload_after_hdr: assert property (@(posedge clk) disable iff (rst)
        (beat_go && in.tlast) || hdr_take |=> !tx_payload_tvalid);

endmodule

// File: logic/udp_echo_core.sv
// UDP echo core that joins the header path and payload gate through the sequencer
`timescale 1ns/100ps

module udp_echo_core import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_hdr_valid,
    output logic      rx_hdr_ready,
    input  ip_addr_t  rx_source_ip,
    input  udp_port_t rx_source_port,
    input  udp_port_t rx_dest_port,
    input  udp_len_t  rx_length,
    input  byte_t     rx_payload_tdata,
    input  logic      rx_payload_tvalid,
    output logic      rx_payload_tready,
    input  logic      rx_payload_tlast,
    input  logic      rx_payload_tuser,
    output logic      tx_hdr_valid,
    input  logic      tx_hdr_ready,
    output ip_addr_t  tx_dest_ip,
    output udp_port_t tx_source_port,
    output udp_port_t tx_dest_port,
    output udp_len_t  tx_length,
    output byte_t     tx_payload_tdata,
    output logic      tx_payload_tvalid,
    input  logic      tx_payload_tready,
    output logic      tx_payload_tlast,
    output logic      tx_payload_tuser,
    output byte_t     led
);

    logic verdict_valid;
    logic verdict_match;
    logic verdict_ready;

    reply_hdr_if  reply_bus ();
    udp_stream_if gate_to_fifo ();
    udp_stream_if fifo_to_seq ();

    echo_header_path hdr_path0 (
        .clk(clk), .rst(rst),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_source_ip(rx_source_ip), .rx_source_port(rx_source_port),
        .rx_dest_port(rx_dest_port), .rx_length(rx_length),
        .verdict_valid(verdict_valid), .verdict_match(verdict_match),
        .verdict_ready(verdict_ready), .reply(reply_bus.src)
    );

    // Payload side runs next to the header path
    echo_payload_gate gate0 (
        .clk(clk), .rst(rst),
        .verdict_valid(verdict_valid), .verdict_match(verdict_match),
        .verdict_ready(verdict_ready),
        .rx_payload_tdata(rx_payload_tdata), .rx_payload_tvalid(rx_payload_tvalid),
        .rx_payload_tready(rx_payload_tready), .rx_payload_tlast(rx_payload_tlast),
        .rx_payload_tuser(rx_payload_tuser), .out(gate_to_fifo.src)
    );

    payload_fifo #(.DEPTH(PAYLOAD_FIFO_DEPTH)) fifo0 (
        .clk(clk), .rst(rst), .in(gate_to_fifo.dst), .out(fifo_to_seq.src)
    );

    echo_frame_sequencer seq0 (
        .clk(clk), .rst(rst), .hdr(reply_bus.dst), .in(fifo_to_seq.dst),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_dest_ip(tx_dest_ip), .tx_source_port(tx_source_port),
        .tx_dest_port(tx_dest_port), .tx_length(tx_length),
        .tx_payload_tdata(tx_payload_tdata), .tx_payload_tvalid(tx_payload_tvalid),
        .tx_payload_tready(tx_payload_tready), .tx_payload_tlast(tx_payload_tlast),
        .tx_payload_tuser(tx_payload_tuser), .led(led)
    );

endmodule

// File: tests/tb_clock_gen.sv
// Testbench clock and reset generator with a 4 ns clock and a 3 cycle reset
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release lines up with the stimulus offset
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: tests/udp_echo_checker.sv
// Checker that watches the tx side of the echo core and compares against expected frames
`timescale 1ns/100ps

module udp_echo_checker import udp_echo_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      tx_hdr_valid,
    input logic      tx_hdr_ready,
    input ip_addr_t  tx_dest_ip,
    input udp_port_t tx_source_port,
    input udp_port_t tx_dest_port,
    input udp_len_t  tx_length,
    input byte_t     tx_payload_tdata,
    input logic      tx_payload_tvalid,
    input logic      tx_payload_tready,
    input logic      tx_payload_tlast,
    input logic      tx_payload_tuser,
    input byte_t     led
);

    // Header entries are {dest_ip, source_port, dest_port, length}
    // Beat entries are {tuser, tlast, tdata}
    logic [79:0] hdr_q [$];
    logic [9:0]  beat_q [$];
    int          pending = 0;
    int          errors = 0;
    byte_t       led_exp = '0;
    logic        first_beat = 1'b0;
    logic [79:0] got_hdr;
    logic [79:0] exp_hdr;
    logic [9:0]  got_beat;
    logic [9:0]  exp_beat;

    function automatic void push_header(input logic [79:0] hdr);
        hdr_q.push_back(hdr);
        pending++;
    endfunction

    function automatic void push_beat(input logic [9:0] beat);
        beat_q.push_back(beat);
        pending++;
    endfunction

    task automatic report(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // led must hold the first byte of the last frame that started
            if (led !== led_exp) begin
                report($sformatf("led is %02h, expected %02h", led, led_exp));
            end
            got_hdr = {tx_dest_ip, tx_source_port, tx_dest_port, tx_length};
            got_beat = {tx_payload_tuser, tx_payload_tlast, tx_payload_tdata};
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    $display("Unexpected tx header at %0t with no echoed frame left", $time);
                    errors++;
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    pending--;
                    if (got_hdr !== exp_hdr) begin
                        report($sformatf("tx header %020h, expected %020h", got_hdr, exp_hdr));
                    end
                end
                first_beat = 1'b1;
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                if (beat_q.size() == 0) begin
                    $display("Unexpected tx payload beat at %0t with no byte expected", $time);
                    errors++;
                end else begin
                    exp_beat = beat_q.pop_front();
                    pending--;
                    if (got_beat !== exp_beat) begin
                        report($sformatf("tx beat %03h, expected %03h", got_beat, exp_beat));
                    end
                    if (first_beat) begin
                        led_exp = exp_beat[7:0];
                    end
                end
                first_beat = 1'b0;
            end
        end
    end

endmodule

// File: tests/udp_echo_tb.sv
// Testbench top for the UDP echo core with frame stimulus, reference model and watchdog
`timescale 1ns/100ps

module udp_echo_tb import udp_echo_pkg::*; ();

    localparam int NUM_FRAMES = 200;
    localparam int MAX_LEN = 40;
    localparam int CLK_NS = 4;
    // Allows several cycles per byte plus header overhead for every frame
    localparam int TIMEOUT_NS = NUM_FRAMES * (MAX_LEN + 20) * 4 * CLK_NS;

    logic      clk, rst;
    logic      rx_hdr_valid, rx_hdr_ready;
    ip_addr_t  rx_source_ip, tx_dest_ip;
    udp_port_t rx_source_port, rx_dest_port, tx_source_port, tx_dest_port;
    udp_len_t  rx_length, tx_length;
    byte_t     rx_payload_tdata, tx_payload_tdata, led;
    logic      rx_payload_tvalid, rx_payload_tready, rx_payload_tlast, rx_payload_tuser;
    logic      tx_hdr_valid, tx_hdr_ready;
    logic      tx_payload_tvalid, tx_payload_tready, tx_payload_tlast, tx_payload_tuser;

    // Frame contents are all drawn before the run starts
    ip_addr_t  src_ip [NUM_FRAMES];
    udp_port_t src_port [NUM_FRAMES];
    udp_port_t dst_port [NUM_FRAMES];
    int        plen [NUM_FRAMES];
    byte_t     pay_data [NUM_FRAMES][MAX_LEN];
    logic      pay_user [NUM_FRAMES][MAX_LEN];

    tb_clock_gen clk_gen0 (.clk(clk), .rst(rst));
    udp_echo_core dut0 (.*);
    udp_echo_checker chk0 (.*);

    // Echo rule matches port 1234, swaps the ports, replies to the sender and keeps the length
    function automatic void expected_reply(input int f);
        if (dst_port[f] == ECHO_PORT) begin
            chk0.push_header({src_ip[f], dst_port[f], src_port[f], 16'(8 + plen[f])});
            for (int b = 0; b < plen[f]; b++) begin
                chk0.push_beat({pay_user[f][b], b == plen[f] - 1, pay_data[f][b]});
            end
        end
    endfunction

    task automatic send_headers();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            rx_hdr_valid = 1'b1;
            rx_source_ip = src_ip[f];
            rx_source_port = src_port[f];
            rx_dest_port = dst_port[f];
            rx_length = 16'(8 + plen[f]);
            do @(posedge clk); while (!rx_hdr_ready);
            #1;
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_payloads();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int b = 0; b < plen[f]; b++) begin
                rx_payload_tvalid = 1'b1;
                rx_payload_tdata = pay_data[f][b];
                rx_payload_tuser = pay_user[f][b];
                rx_payload_tlast = b == plen[f] - 1;
                do @(posedge clk); while (!rx_payload_tready);
                #1;
            end
        end
        rx_payload_tvalid = 1'b0;
    endtask

    task automatic toggle_tx_ready();
        forever begin
            tx_hdr_ready = 1'($urandom % 2);
            tx_payload_tready = ($urandom % 4) != 0;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : main
        void'($urandom(32'h9a3c_debe));
        {rx_hdr_valid, rx_source_ip, rx_source_port, rx_dest_port, rx_length} = '0;
        {rx_payload_tdata, rx_payload_tvalid, rx_payload_tlast, rx_payload_tuser} = '0;
        tx_hdr_ready = 1'b0;
        tx_payload_tready = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            src_ip[f] = $urandom;
            src_port[f] = 16'($urandom);
            dst_port[f] = ($urandom % 2) ? ECHO_PORT : 16'($urandom);
            plen[f] = 1 + $urandom % MAX_LEN;
            for (int b = 0; b < MAX_LEN; b++) begin
                pay_data[f][b] = 8'($urandom);
                pay_user[f][b] = 1'($urandom);
            end
            expected_reply(f);
        end
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        fork
            toggle_tx_ready();
        join_none
        fork
            send_headers();
            send_payloads();
        join
        wait (chk0.pending == 0);
        // Quiet period to catch any extra header or beat
        repeat (100) @(posedge clk);
        $display("Run finished with %0d errors and %0d expected entries left",
                 chk0.errors, chk0.pending);
        if (chk0.errors == 0 && chk0.pending == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout at %0t with %0d expected entries still outstanding",
                 $time, chk0.pending);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: compile.f
logic/udp_echo_pkg.sv
logic/udp_stream_if.sv
logic/reply_hdr_if.sv
logic/echo_header_path.sv
logic/echo_payload_gate.sv
logic/payload_fifo.sv
logic/echo_frame_sequencer.sv
logic/udp_echo_core.sv
tests/tb_clock_gen.sv
tests/udp_echo_checker.sv
tests/udp_echo_tb.sv

// File: Bender.yml
package:
  name: udp_echo

sources:
  - files:
      - logic/udp_echo_pkg.sv
      - logic/udp_stream_if.sv
      - logic/reply_hdr_if.sv
      - logic/echo_header_path.sv
      - logic/echo_payload_gate.sv
      - logic/payload_fifo.sv
      - logic/echo_frame_sequencer.sv
      - logic/udp_echo_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/udp_echo_checker.sv
      - tests/udp_echo_tb.sv
